//--- files.f
cd_pkg.sv
cd_if.sv
cd_csr.sv
cd_frame_ram.sv
cd_tx_bytes.sv
cd_tx_ser.sv
cd_rx_des.sv
cd_rx_bytes.sv
cdbus.sv
tb_cdbus.sv

//--- run.sh
#!/bin/sh
# build and run the cdbus testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_cdbus -o sim_cdbus > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_cdbus > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

//--- tb_cdbus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus testbench
// host register tasks, 8N1 line model, loopback and tx line checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_cdbus import cd_pkg::*; ();
    localparam int BIT_CLKS = 16;   // reset divisor plus one

    logic       clk;
    logic       reset;
    logic [3:0] csr_address;
    logic       csr_read;
    logic       csr_write;
    word_t      csr_writedata;
    word_t      csr_readdata;
    logic       irq;
    logic       tx;
    logic       rx;
    logic       line_rx;
    logic       loopback;
    logic [4:0] mask_shadow;    // what the host last wrote to INT_MASK
    int         checks;
    int         errors;
    int         prop_errors;
    byte_t      frame[$];       // src, dst, len, data
    byte_t      saved[$];

    assign rx = loopback ? tx : line_rx;

    cdbus dut0 (
        .clk, .reset, .csr_address, .csr_read, .csr_write, .csr_writedata,
        .csr_readdata, .irq, .rx, .tx
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    a_tx_high_in_reset: assert property (@(posedge clk) reset |=> tx)
        else begin
            $display("tx line not high after reset");
            prop_errors = prop_errors + 1;
        end

    a_irq_masked: assert property (@(posedge clk) disable iff (reset)
        mask_shadow == '0 |-> !irq)
        else begin
            $display("irq raised with all interrupts masked");
            prop_errors = prop_errors + 1;
        end

    // bitwise modbus crc over the reflected 0xa001 poly
    function automatic logic [15:0] crc_update(logic [15:0] crc, byte_t b);
        logic [15:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c = c >> 1;
            if (fb) c = c ^ 16'ha001;
        end
        return c;
    endfunction

    function automatic logic [15:0] frame_crc();
        logic [15:0] c;
        c = 16'hffff;
        foreach (frame[i]) c = crc_update(c, frame[i]);
        return c;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (expected == actual) else begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input word_t data);
        @(posedge clk);
        csr_address   <= addr;
        csr_writedata <= data;
        csr_write     <= 1'b1;
        @(posedge clk);
        csr_write <= 1'b0;
        if (addr == CSR_INT_MASK) mask_shadow = data[4:0];
    endtask

    task automatic read_reg(input logic [3:0] addr, output word_t data);
        @(posedge clk);
        csr_address <= addr;
        csr_read    <= 1'b1;
        @(posedge clk);
        csr_read <= 1'b0;
        @(negedge clk);     // readdata settled one cycle after the read
        data = csr_readdata;
    endtask

    task automatic wait_status(input int bitn, input logic value, input string name);
        word_t s;
        int    n;
        n = 0;
        read_reg(CSR_STATUS, s);
        while (s[bitn] !== value && n < 4000) begin
            read_reg(CSR_STATUS, s);
            n++;
        end
        if (s[bitn] !== value) begin
            $display("timeout waiting for %s", name);
            errors++;
        end
    endtask

    task automatic build_frame(input byte_t dst, input int n, input int len_adj);
        frame.delete();
        frame.push_back(8'h11);
        frame.push_back(dst);
        frame.push_back(8'(n + len_adj));
        for (int i = 0; i < n; i++) frame.push_back(8'($urandom));
    endtask

    task automatic host_send();
        foreach (frame[i]) write_reg(CSR_TX_DATA, {24'd0, frame[i]});
        write_reg(CSR_TX_CTRL, 32'h1);
    endtask

    task automatic line_send_byte(input byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};     // stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            line_rx <= bits[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic line_send_frame(input logic [15:0] crc_flip);
        logic [15:0] crc;
        crc = frame_crc() ^ crc_flip;
        foreach (frame[i]) line_send_byte(frame[i]);
        line_send_byte(crc[7:0]);
        line_send_byte(crc[15:8]);
    endtask

    // samples tx at mid-bit and compares with the frame plus its crc
    task automatic tx_line_check();
        logic [15:0] crc;
        byte_t       line_bytes[$];
        byte_t       got;
        int          n;
        crc = frame_crc();
        line_bytes = frame;
        line_bytes.push_back(crc[7:0]);
        line_bytes.push_back(crc[15:8]);
        foreach (line_bytes[k]) begin
            n = 0;
            @(negedge clk);
            while (tx !== 1'b0 && n < 20000) begin
                @(negedge clk);
                n++;
            end
            if (tx !== 1'b0) begin
                $display("timeout waiting for the start bit of tx byte %0d", k);
                errors++;
                return;
            end
            repeat (BIT_CLKS / 2) @(negedge clk);
            check_value("tx start bit", 0, 32'(tx));
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                got[i] = tx;
            end
            check_value("tx byte", 32'(line_bytes[k]), 32'(got));
            repeat (BIT_CLKS) @(negedge clk);
            check_value("tx stop bit", 1, 32'(tx));
        end
    endtask

    // reads length and bytes back, then releases the buffer
    task automatic check_rx_frame(input string name);
        word_t v;
        read_reg(CSR_RX_LEN, v);
        check_value({name, " rx len"}, 32'(frame.size()), v);
        foreach (frame[i]) begin
            read_reg(CSR_RX_DATA, v);
            check_value({name, " rx data"}, 32'(frame[i]), v);
        end
        write_reg(CSR_RX_CTRL, 32'h1);
    endtask

    initial begin
        word_t v;
        void'($urandom(32'h5e10));
        checks        = 0;
        errors        = 0;
        prop_errors   = 0;
        mask_shadow   = '0;
        reset         = 1'b1;
        csr_address   = '0;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_writedata = '0;
        line_rx       = 1'b1;
        loopback      = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        read_reg(CSR_STATUS, v);
        check_value("status after reset", 0, v);
        check_value("tx after reset", 1, 32'(tx));
        check_value("irq after reset", 0, 32'(irq));
        wait_status(STAT_BUS_IDLE, 1'b1, "bus idle after reset");

        // loopback send with the tx line checked on the way
        @(posedge clk);
        loopback <= 1'b1;
        write_reg(CSR_FILTER, 32'h21);
        build_frame(8'h21, 6, 0);
        host_send();
        fork
            tx_line_check();
            wait_status(STAT_RX_PENDING, 1'b1, "rx pending after loopback send");
        join
        read_reg(CSR_STATUS, v);
        check_value("tx pending after send", 0, 32'(v[STAT_TX_PENDING]));
        check_rx_frame("loopback");

        build_frame(8'h42, 4, 0);   // not our address
        host_send();
        wait_status(STAT_TX_PENDING, 1'b0, "tx done, other destination");
        wait_status(STAT_BUS_IDLE, 1'b1, "bus idle, other destination");
        read_reg(CSR_STATUS, v);
        check_value("rx pending, other destination", 0, 32'(v[STAT_RX_PENDING]));
        check_value("rx error, other destination", 0, 32'(v[STAT_RX_ERROR]));

        build_frame(BROADCAST, 3, 0);
        host_send();
        wait_status(STAT_RX_PENDING, 1'b1, "rx pending, broadcast");
        check_rx_frame("broadcast");

        // crc and length faults from the line model
        @(posedge clk);
        loopback <= 1'b0;
        build_frame(8'h21, 5, 0);
        line_send_frame(16'h0010);
        wait_status(STAT_BUS_IDLE, 1'b1, "bus idle after bad crc");
        read_reg(CSR_STATUS, v);
        check_value("rx error, bad crc", 1, 32'(v[STAT_RX_ERROR]));
        check_value("rx pending, bad crc", 0, 32'(v[STAT_RX_PENDING]));
        check_value("irq masked, bad crc", 0, 32'(irq));
        write_reg(CSR_INT_MASK, 32'h1 << STAT_RX_ERROR);
        @(negedge clk);
        check_value("irq unmasked, bad crc", 1, 32'(irq));
        write_reg(CSR_STATUS, 32'h1 << STAT_RX_ERROR);
        @(negedge clk);
        check_value("irq after error clear", 0, 32'(irq));

        build_frame(8'h21, 5, 1);   // length field one too high
        line_send_frame(16'h0000);
        wait_status(STAT_BUS_IDLE, 1'b1, "bus idle after bad length");
        read_reg(CSR_STATUS, v);
        check_value("rx error, bad length", 1, 32'(v[STAT_RX_ERROR]));
        check_value("rx pending, bad length", 0, 32'(v[STAT_RX_PENDING]));
        check_value("irq unmasked, bad length", 1, 32'(irq));
        write_reg(CSR_STATUS, 32'h1 << STAT_RX_ERROR);
        write_reg(CSR_INT_MASK, 32'h0);

        // second frame while the first is still unread
        build_frame(8'h21, 7, 0);
        line_send_frame(16'h0000);
        wait_status(STAT_RX_PENDING, 1'b1, "rx pending, first frame");
        saved = frame;
        build_frame(8'h21, 2, 0);
        line_send_frame(16'h0000);
        wait_status(STAT_RX_LOST, 1'b1, "rx lost, second frame");
        frame = saved;
        check_rx_frame("kept frame");
        write_reg(CSR_STATUS, 32'h1 << STAT_RX_LOST);
        read_reg(CSR_STATUS, v);
        check_value("rx lost after clear", 0, 32'(v[STAT_RX_LOST]));

        $display("checks %0d, check errors %0d, property errors %0d",
                 checks, errors, prop_errors);
        if (errors == 0 && prop_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule

//--- cdbus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus controller top level
// register port, tx and rx buffers, byte engines and line coders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cdbus import cd_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] csr_address,
    input  logic       csr_read,
    input  logic       csr_write,
    input  word_t      csr_writedata,
    output word_t      csr_readdata,
    output logic       irq,
    input  logic       rx,
    output logic       tx
);
    cd_tx_byte_if tx_if ();
    cd_rx_byte_if rx_if ();

    div_t  div;
    byte_t filter;
    logic  bus_idle;
    logic  tx_wr_en;
    addr_t tx_wr_addr;
    logic  tx_start;
    addr_t tx_len;
    logic  tx_done;
    addr_t tx_rd_addr;
    byte_t tx_rd_data;
    addr_t rx_rd_addr;
    byte_t rx_rd_byte;
    logic  rx_busy;
    logic  rx_wr_en;
    addr_t rx_wr_addr;
    byte_t rx_wr_data;
    logic  rx_frame_ok;
    addr_t rx_frame_len;
    logic  rx_frame_bad;
    logic  rx_frame_drop;

    assign bus_idle = rx_if.bus_idle;   // also gates the sender

    cd_csr csr0 (
        .clk, .reset, .csr_address, .csr_read, .csr_write, .csr_writedata,
        .csr_readdata, .irq, .div, .filter, .tx_wr_en, .tx_wr_addr, .tx_start,
        .tx_len, .tx_done, .rx_frame_ok, .rx_frame_len, .rx_frame_bad,
        .rx_frame_drop, .rx_rd_addr, .rx_rd_byte, .rx_busy, .bus_idle
    );

    cd_frame_ram tx_ram (
        .clk, .wr_en(tx_wr_en), .wr_addr(tx_wr_addr), .wr_data(csr_writedata[7:0]),
        .rd_addr(tx_rd_addr), .rd_data(tx_rd_data)
    );

    cd_frame_ram rx_ram (
        .clk, .wr_en(rx_wr_en), .wr_addr(rx_wr_addr), .wr_data(rx_wr_data),
        .rd_addr(rx_rd_addr), .rd_data(rx_rd_byte)
    );

    cd_tx_bytes tx_bytes0 (
        .clk, .reset, .tx_start, .tx_len, .ram_rd_data(tx_rd_data),
        .ram_rd_addr(tx_rd_addr), .tx_done, .bytes(tx_if.src)
    );

    cd_tx_ser tx_ser0 (.clk, .reset, .div, .bus_idle, .tx, .bytes(tx_if.dst));

    cd_rx_des rx_des0 (.clk, .reset, .div, .rx, .bytes(rx_if.src));

    cd_rx_bytes rx_bytes0 (
        .clk, .reset, .filter, .rx_busy, .ram_wr_en(rx_wr_en), .ram_wr_addr(rx_wr_addr),
        .ram_wr_data(rx_wr_data), .rx_frame_ok, .rx_frame_len, .rx_frame_bad,
        .rx_frame_drop, .bytes(rx_if.dst)
    );
endmodule

//--- cd_rx_bytes.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus receive frame checker
// stores bytes, runs crc, length and address checks at frame end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_rx_bytes import cd_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  byte_t filter,
    input  logic  rx_busy,
    output logic  ram_wr_en,
    output addr_t ram_wr_addr,
    output byte_t ram_wr_data,
    output logic  rx_frame_ok,
    output addr_t rx_frame_len,
    output logic  rx_frame_bad,
    output logic  rx_frame_drop,
    cd_rx_byte_if.dst bytes
);
    logic [6:0] count;
    crc_t       crc;
    byte_t      len_field;
    logic       dest_ok;
    logic       skip;       // buffer was busy during the frame
    logic       good;

    assign ram_wr_en   = bytes.strobe && !rx_busy && (count < 7'(MAX_FRAME));
    assign ram_wr_addr = count[5:0];
    assign ram_wr_data = bytes.data;

    // src, dst, len, data, crc lo, crc hi
    assign good = (crc == '0) && (count <= 7'(MAX_FRAME)) &&
                  ({2'b00, count} == {1'b0, len_field} + 9'd5);
    assign rx_frame_bad  = bytes.frame_end && !good;
    assign rx_frame_drop = bytes.frame_end && good && dest_ok && (skip || rx_busy);
    assign rx_frame_ok   = bytes.frame_end && good && dest_ok && !(skip || rx_busy);
    assign rx_frame_len  = 6'(count - 7'd2);    // crc bytes excluded

    always_ff @(posedge clk) begin
        if (reset || bytes.frame_end) begin
            count   <= '0;
            crc     <= CRC_INIT;
            dest_ok <= 1'b0;
            skip    <= 1'b0;
        end else if (bytes.strobe) begin
            crc  <= crc16_step(crc, bytes.data);
            skip <= skip | rx_busy;
            if (count != 7'h7f) count <= count + 1'b1;
            if (count == 7'd1) dest_ok <= (bytes.data == filter) || (bytes.data == BROADCAST);
            if (count == 7'd2) len_field <= bytes.data;
        end
    end

    // a byte strobe on the frame end cycle would be lost
    a_end_apart_from_byte: assert property (@(posedge clk) disable iff (reset)
        bytes.frame_end |-> !bytes.strobe);
    // an accepted frame locks the buffer from the next cycle on
    a_ok_locks: assert property (@(posedge clk) disable iff (reset)
        rx_frame_ok |=> rx_busy);
endmodule

//--- cd_rx_des.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus deserializer
// synchronises rx, samples 8N1 characters at mid-bit and
// times the idle gap that ends a frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_rx_des import cd_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  div_t div,
    input  logic rx,
    cd_rx_byte_if.src bytes
);
    des_state_t state;
    logic [1:0] rx_sync;
    logic       rxd;
    div_t       cnt;
    logic [2:0] bitn;
    byte_t      shreg;
    div_t       idle_cnt;
    logic [3:0] idle_bits;
    logic       got_byte;   // frame has at least one byte

    assign rxd = rx_sync[1];
    assign bytes.data = shreg;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync         <= 2'b11;
            state           <= DES_IDLE;
            cnt             <= '0;
            bitn            <= '0;
            idle_cnt        <= '0;
            idle_bits       <= '0;
            got_byte        <= 1'b0;
            bytes.strobe    <= 1'b0;
            bytes.frame_end <= 1'b0;
            bytes.bus_idle  <= 1'b0;
        end else begin
            rx_sync         <= {rx_sync[0], rx};
            bytes.strobe    <= 1'b0;
            bytes.frame_end <= 1'b0;
            cnt             <= cnt + 1'b1;
            case (state)
                DES_IDLE: begin
                    cnt <= '0;
                    if (!rxd) state <= DES_START;
                end
                DES_START: if (cnt == (div >> 1)) begin
                    cnt   <= '0;
                    state <= rxd ? DES_IDLE : DES_DATA;     // glitch
                end
                DES_DATA: if (cnt == div) begin
                    cnt   <= '0;
                    shreg <= {rxd, shreg[7:1]};
                    bitn  <= bitn + 1'b1;
                    if (bitn == 3'd7) state <= DES_STOP;
                end
                DES_STOP: if (cnt == div) begin
                    state        <= DES_IDLE;
                    bytes.strobe <= rxd;    // low stop bit drops the byte
                    got_byte     <= got_byte | rxd;
                end
                default: state <= DES_IDLE;
            endcase

            if (state != DES_IDLE || !rxd) begin
                idle_cnt       <= '0;
                idle_bits      <= '0;
                bytes.bus_idle <= 1'b0;
            end else if (!bytes.bus_idle) begin
                if (idle_cnt == div) begin
                    idle_cnt  <= '0;
                    idle_bits <= idle_bits + 1'b1;
                    if (idle_bits == 4'(IDLE_BITS - 1)) begin
                        bytes.bus_idle  <= 1'b1;
                        bytes.frame_end <= got_byte;
                        got_byte        <= 1'b0;
                    end
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end
endmodule

//--- cd_tx_ser.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus serializer
// waits for an idle bus, then sends 8N1 characters back to back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_tx_ser import cd_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  div_t div,
    input  logic bus_idle,
    output logic tx,
    cd_tx_byte_if.dst bytes
);
    ser_state_t state;
    div_t       cnt;
    logic [2:0] bitn;
    byte_t      shreg;
    logic       in_frame;   // later bytes skip the idle wait
    logic       bit_end;
    logic       load;

    assign bit_end = (cnt == div);
    assign load = bytes.valid && ((state == SER_IDLE && (in_frame || bus_idle)) ||
                                  (state == SER_STOP && bit_end && in_frame));
    assign bytes.ack = load;
    assign tx = (state == SER_START) ? 1'b0 : (state == SER_DATA) ? shreg[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= SER_IDLE;
            cnt      <= '0;
            bitn     <= '0;
            in_frame <= 1'b0;
        end else begin
            cnt <= (state == SER_IDLE || bit_end) ? '0 : cnt + 1'b1;
            if (load) begin
                shreg    <= bytes.data;
                in_frame <= !bytes.last;
                state    <= SER_START;
            end else begin
                case (state)
                    SER_START: if (bit_end) state <= SER_DATA;
                    SER_DATA: if (bit_end) begin
                        shreg <= shreg >> 1;    // lsb first
                        bitn  <= bitn + 1'b1;
                        if (bitn == 3'd7) state <= SER_STOP;
                    end
                    SER_STOP: if (bit_end) state <= SER_IDLE;
                    default: ;
                endcase
            end
        end
    end
endmodule

//--- cd_tx_bytes.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus transmit byte source
// walks the tx buffer, runs the crc and appends it low byte first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_tx_bytes import cd_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  tx_start,
    input  addr_t tx_len,
    input  byte_t ram_rd_data,
    output addr_t ram_rd_addr,
    output logic  tx_done,
    cd_tx_byte_if.src bytes
);
    tx_state_t state;
    addr_t     idx;
    addr_t     len;
    crc_t      crc;
    logic      crc_hi;

    assign ram_rd_addr = idx;
    assign bytes.valid = (state == TX_DATA) || (state == TX_CRC);
    assign bytes.data  = (state == TX_CRC) ? (crc_hi ? crc[15:8] : crc[7:0]) : ram_rd_data;
    assign bytes.last  = (state == TX_CRC) && crc_hi;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            idx     <= '0;
            crc     <= CRC_INIT;
            crc_hi  <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                TX_IDLE: if (tx_start) begin
                    len    <= tx_len;
                    idx    <= '0;
                    crc    <= CRC_INIT;
                    crc_hi <= 1'b0;
                    state  <= TX_READ;
                end
                TX_READ: state <= TX_DATA;  // ram latency
                TX_DATA: if (bytes.ack) begin
                    crc   <= crc16_step(crc, ram_rd_data);
                    idx   <= idx + 1'b1;
                    state <= (idx == len - 1'b1) ? TX_CRC : TX_READ;
                end
                TX_CRC: if (bytes.ack) begin
                    crc_hi <= 1'b1;
                    if (crc_hi) begin
                        tx_done <= 1'b1;
                        state   <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // also needs the tx buffer to stay untouched while sending
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        bytes.valid && !bytes.ack |=> bytes.valid && $stable(bytes.data) && $stable(bytes.last));
endmodule

//--- cd_frame_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus frame buffer
// 64 byte simple dual-port memory, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_frame_ram import cd_pkg::*; (
    input  logic  clk,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  byte_t wr_data,
    input  addr_t rd_addr,
    output byte_t rd_data
);
    byte_t mem [MAX_FRAME];

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];
    end
endmodule

//--- cd_csr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus register port
// host decode, status and irq, buffer pointers and frame lengths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_csr import cd_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] csr_address,
    input  logic       csr_read,
    input  logic       csr_write,
    input  word_t      csr_writedata,
    output word_t      csr_readdata,
    output logic       irq,
    output div_t       div,
    output byte_t      filter,
    output logic       tx_wr_en,
    output addr_t      tx_wr_addr,
    output logic       tx_start,
    output addr_t      tx_len,
    input  logic       tx_done,
    input  logic       rx_frame_ok,
    input  addr_t      rx_frame_len,
    input  logic       rx_frame_bad,
    input  logic       rx_frame_drop,
    output addr_t      rx_rd_addr,
    input  byte_t      rx_rd_byte,
    output logic       rx_busy,
    input  logic       bus_idle
);
    logic [4:0] status;
    logic [4:0] int_mask;
    logic       tx_pending;
    logic       rx_pending;
    logic       rx_error;
    logic       rx_lost;
    logic       rx_release;
    logic       rx_rd;
    logic       rd_rx_sel;      // last read was RX_DATA
    addr_t      rx_len;
    word_t      readdata_q;

    assign tx_wr_en   = csr_write && csr_address == CSR_TX_DATA && !tx_pending;
    assign tx_start   = csr_write && csr_address == CSR_TX_CTRL && csr_writedata[0] && !tx_pending;
    assign tx_len     = tx_wr_addr;
    assign rx_release = csr_write && csr_address == CSR_RX_CTRL && csr_writedata[0];
    assign rx_rd      = csr_read && csr_address == CSR_RX_DATA;
    assign rx_busy    = rx_pending;
    assign irq        = |(status & int_mask);
    // rx ram read is already registered
    assign csr_readdata = rd_rx_sel ? {24'd0, rx_rd_byte} : readdata_q;

    always_comb begin
        status = '0;
        status[STAT_RX_PENDING] = rx_pending;
        status[STAT_TX_PENDING] = tx_pending;
        status[STAT_RX_ERROR]   = rx_error;
        status[STAT_RX_LOST]    = rx_lost;
        status[STAT_BUS_IDLE]   = bus_idle;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            div        <= DIV_RESET;
            filter     <= '0;
            int_mask   <= '0;
            tx_pending <= 1'b0;
            rx_pending <= 1'b0;
            rx_error   <= 1'b0;
            rx_lost    <= 1'b0;
            tx_wr_addr <= '0;
            rx_rd_addr <= '0;
            rd_rx_sel  <= 1'b0;
        end else begin
            if (csr_write) begin
                case (csr_address)
                    CSR_DIV:      div <= csr_writedata[15:0];
                    CSR_FILTER:   filter <= csr_writedata[7:0];
                    CSR_INT_MASK: int_mask <= csr_writedata[4:0];
                    CSR_STATUS: begin   // write one to clear
                        if (csr_writedata[STAT_RX_ERROR]) rx_error <= 1'b0;
                        if (csr_writedata[STAT_RX_LOST]) rx_lost <= 1'b0;
                    end
                    default: ;
                endcase
            end
            if (rx_frame_bad) rx_error <= 1'b1;
            if (rx_frame_drop) rx_lost <= 1'b1;

            if (tx_wr_en) tx_wr_addr <= tx_wr_addr + 1'b1;
            if (tx_start) begin
                tx_pending <= 1'b1;
                tx_wr_addr <= '0;
            end else if (tx_done) begin
                tx_pending <= 1'b0;
            end

            if (rx_frame_ok) begin
                rx_pending <= 1'b1;
                rx_len     <= rx_frame_len;
                rx_rd_addr <= '0;
            end else if (rx_release) begin
                rx_pending <= 1'b0;
                rx_rd_addr <= '0;
            end else if (rx_rd) begin
                rx_rd_addr <= rx_rd_addr + 1'b1;
            end
            rd_rx_sel <= rx_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_read) begin
            case (csr_address)
                CSR_DIV:      readdata_q <= {16'd0, div};
                CSR_FILTER:   readdata_q <= {24'd0, filter};
                CSR_STATUS:   readdata_q <= {27'd0, status};
                CSR_INT_MASK: readdata_q <= {27'd0, int_mask};
                CSR_RX_LEN:   readdata_q <= {26'd0, rx_len};
                default:      readdata_q <= '0;
            endcase
        end
    end

    // a done pulse only ends an accepted send
    a_done_while_pending: assert property (@(posedge clk) disable iff (reset)
        tx_done |-> tx_pending);
endmodule

//--- cd_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus internal byte streams
// transmit bytes towards the serializer, received bytes from the line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface cd_tx_byte_if import cd_pkg::*; ();
    byte_t data;
    logic  valid;
    logic  last;    // final crc byte
    logic  ack;

    modport src (output data, valid, last, input ack);
    modport dst (input data, valid, last, output ack);
endinterface

interface cd_rx_byte_if import cd_pkg::*; ();
    byte_t data;
    logic  strobe;
    logic  frame_end;
    logic  bus_idle;

    modport src (output data, strobe, frame_end, bus_idle);
    modport dst (input data, strobe, frame_end, bus_idle);
endinterface

//--- cd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cdbus shared definitions
// widths, register map, status bits, limits, FSM states and CRC step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cd_pkg;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  addr_t;
    typedef logic [15:0] div_t;
    typedef logic [15:0] crc_t;

    localparam logic [3:0] CSR_DIV      = 4'd0;
    localparam logic [3:0] CSR_FILTER   = 4'd1;
    localparam logic [3:0] CSR_STATUS   = 4'd2;
    localparam logic [3:0] CSR_INT_MASK = 4'd3;
    localparam logic [3:0] CSR_TX_DATA  = 4'd4;
    localparam logic [3:0] CSR_TX_CTRL  = 4'd5;
    localparam logic [3:0] CSR_RX_DATA  = 4'd6;
    localparam logic [3:0] CSR_RX_CTRL  = 4'd7;
    localparam logic [3:0] CSR_RX_LEN   = 4'd8;

    localparam int STAT_RX_PENDING = 0;
    localparam int STAT_TX_PENDING = 1;
    localparam int STAT_RX_ERROR   = 2;   // crc or length fault
    localparam int STAT_RX_LOST    = 3;
    localparam int STAT_BUS_IDLE   = 4;

    localparam int    IDLE_BITS = 12;     // bit times of high line
    localparam int    MAX_FRAME = 64;
    localparam div_t  DIV_RESET = 16'd15;
    localparam crc_t  CRC_INIT  = 16'hffff;
    localparam byte_t BROADCAST = 8'hff;

    typedef enum logic [1:0] {TX_IDLE, TX_READ, TX_DATA, TX_CRC} tx_state_t;
    typedef enum logic [1:0] {SER_IDLE, SER_START, SER_DATA, SER_STOP} ser_state_t;
    typedef enum logic [1:0] {DES_IDLE, DES_START, DES_DATA, DES_STOP} des_state_t;

    // one modbus crc byte step over the reflected poly
    function automatic crc_t crc16_step(crc_t crc, byte_t data);
        crc_t c;
        c = crc ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 16'ha001) : (c >> 1);
        end
        return c;
    endfunction
endpackage
